// ==== testbench/comp_cases.txt ====
# name flags(hex) src_len(hex) task(hex) words remainder(hex) backpressure engine_reset len_bytes
# len_bytes is the payload word count padded to even, times 4
even_4        4 00000010 005  4 0 0 0  16
even_2        2 00000008 3ff  2 0 0 0   8
odd_1_rem1    1 00000003 011  1 1 0 0   8
odd_3_rem3    4 0000000a 022  3 3 0 0  16
odd_5_rem7    2 00000011 133  5 7 0 0  24
even_6_rem3   0 00000016 044  6 3 0 0  24
odd_7_rem1    7 0000001b 255  7 1 1 0  32
bp_long_41    4 000000a1 066 41 7 1 0 168
bp_long_48    5 000000c0 377 48 0 1 0 192
after_rst_9   2 00000022 088  9 3 1 1  40
after_rst_2   6 00000008 099  2 0 0 0   8
odd_33_rem1   1 00000083 1ab 33 1 1 0 136

// ==== comp_unit.f ====
+incdir+include
design/comp_pkg.sv
design/tx_frame_parser.sv
design/beat_buffer.sv
design/rx_frame_builder.sv
design/dcr_status_regs.sv
design/comp_unit.sv
testbench/tb_comp_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the comp_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f comp_unit.f \
   --top-module tb_comp_unit -o tb_comp_unit > build.log 2>&1 &&
   ./obj_dir/tb_comp_unit > sim.log 2>&1 ||
   { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/tb_comp_unit.sv ====
`timescale 1ns/1ps
`include "comp_macros.svh"

module tb_comp_unit;
   localparam int WAIT_LIMIT = 2000;

   logic        clk;
   logic        rst_n;
   logic        rst_engine_ack;
   logic        rst_engine_req;
   logic [31:0] tx_d;
   logic [3:0]  tx_rem;
   logic        tx_sof_n;
   logic        tx_eof_n;
   logic        tx_sop_n;
   logic        tx_eop_n;
   logic        tx_src_rdy_n;
   logic        tx_dst_rdy_n;
   logic [31:0] rx_d;
   logic [3:0]  rx_rem;
   logic        rx_sof_n;
   logic        rx_eof_n;
   logic        rx_sop_n;
   logic        rx_eop_n;
   logic        rx_src_rdy_n;
   logic        rx_dst_rdy_n;
   logic [0:9]  dcr_abus;
   logic [0:31] dcr_dbus_in;
   logic        dcr_read;
   logic        dcr_write;
   logic        dcr_ack;
   logic [0:31] dcr_dbus_out;

   logic [31:0] lcg_state;
   logic [31:0] hdr_words [`COMP_HDR_WORDS];
   logic [31:0] pay_words [$];
   logic [31:0] trailer_word;
   // {sof_n, sop_n, eop_n, eof_n, data}
   logic [35:0] exp_words [$];
   int          beats_total;

   // current case from the file
   string       case_name;
   logic [2:0]  c_flags;
   logic [31:0] c_src_len;
   logic [9:0]  c_task;
   int          c_words;
   logic [3:0]  c_rem;
   int          c_bp;
   int          c_rst;
   int          c_len;

   comp_unit dut_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .rst_engine_req_o (rst_engine_req),
      .rst_engine_ack_i (rst_engine_ack),
      .tx_d_i           (tx_d),
      .tx_rem_i         (tx_rem),
      .tx_sof_n_i       (tx_sof_n),
      .tx_eof_n_i       (tx_eof_n),
      .tx_sop_n_i       (tx_sop_n),
      .tx_eop_n_i       (tx_eop_n),
      .tx_src_rdy_n_i   (tx_src_rdy_n),
      .tx_dst_rdy_n_o   (tx_dst_rdy_n),
      .rx_d_o           (rx_d),
      .rx_rem_o         (rx_rem),
      .rx_sof_n_o       (rx_sof_n),
      .rx_eof_n_o       (rx_eof_n),
      .rx_sop_n_o       (rx_sop_n),
      .rx_eop_n_o       (rx_eop_n),
      .rx_src_rdy_n_o   (rx_src_rdy_n),
      .rx_dst_rdy_n_i   (rx_dst_rdy_n),
      .dcr_abus_i       (dcr_abus),
      .dcr_dbus_i       (dcr_dbus_in),
      .dcr_read_i       (dcr_read),
      .dcr_write_i      (dcr_write),
      .dcr_ack_o        (dcr_ack),
      .dcr_dbus_o       (dcr_dbus_out)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // remainder 1, 3, 7 clears the low 1, 2, 3 byte lanes
   function automatic logic [31:0] drop_bytes(input logic [31:0] w, input logic [3:0] rem);
      case (rem)
         4'h1: return w & 32'hffff_ff00;
         4'h3: return w & 32'hffff_0000;
         4'h7: return w & 32'hff00_0000;
         default: return w;
      endcase
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
         else abort_run($sformatf("FAIL %s %s: expected %h, actual %h",
                                  case_name, what, exp, act));
   endtask

   task automatic check_rx_idle(input string what);
      check_value(what, 32'h1f, {rx_src_rdy_n, rx_sof_n, rx_sop_n, rx_eop_n, rx_eof_n});
   endtask

   task automatic send_word(input logic [31:0] d, input logic sof_n, input logic sop_n,
                            input logic eop_n, input logic eof_n, input logic [3:0] rem);
      int waited;
      tx_d = d;
      tx_sof_n = sof_n;
      tx_sop_n = sop_n;
      tx_eop_n = eop_n;
      tx_eof_n = eof_n;
      tx_rem = rem;
      tx_src_rdy_n = 1'b0;
      waited = 0;
      // ready only changes on the rising edge
      while (tx_dst_rdy_n) begin
         waited++;
         assert (waited < WAIT_LIMIT) else abort_run("timeout waiting for TX ready");
         @(negedge clk);
      end
      @(negedge clk);
   endtask

   task automatic send_frame();
      int n;
      n = pay_words.size();
      for (int i = 0; i < `COMP_HDR_WORDS; i++) begin
         send_word(hdr_words[i], i != 0, 1'b1, 1'b1, 1'b1, 4'h0);
      end
      for (int i = 0; i < n; i++) begin
         send_word(pay_words[i], 1'b1, i != 0, i != n - 1, 1'b1, (i == n - 1) ? c_rem : 4'h0);
      end
      send_word(trailer_word, 1'b1, 1'b1, 1'b1, 1'b0, 4'h0);
      tx_src_rdy_n = 1'b1;
      tx_eof_n = 1'b1;
   endtask

   task automatic build_frame();
      logic [31:0] w;
      logic [31:0] d;
      int          padded;
      pay_words.delete();
      exp_words.delete();
      for (int i = 0; i < `COMP_HDR_WORDS; i++) begin
         hdr_words[i] = lcg_next();
      end
      // random filler around the decoded fields
      w = hdr_words[`COMP_FLAG_WORD];
      hdr_words[`COMP_FLAG_WORD] = {c_flags, w[28:0]};
      hdr_words[`COMP_LEN_WORD] = c_src_len;
      w = hdr_words[`COMP_TASK_WORD];
      hdr_words[`COMP_TASK_WORD] = {w[31:10], c_task};
      for (int i = 0; i < c_words; i++) begin
         pay_words.push_back(lcg_next());
      end
      trailer_word = lcg_next();
      padded = c_words + (c_words % 2);
      assert (padded * 4 == c_len)
         else abort_run({"length column disagrees with the word count in case ", case_name});
      for (int i = 0; i < padded; i++) begin
         d = 32'h0;
         if (i < c_words) d = pay_words[i];
         if (i == c_words - 1) d = drop_bytes(d, c_rem);
         exp_words.push_back({i != 0, i != 0, i != padded - 1, 1'b1, d});
      end
      exp_words.push_back({4'b1111, c_flags, 1'b1, 28'h0});
      exp_words.push_back({4'b1111, 32'(c_len)});
      exp_words.push_back({4'b1111, 22'h0, c_task});
      exp_words.push_back({4'b1110, 32'h0});
   endtask

   task automatic collect_frame();
      int          waited;
      int          idx;
      logic        done;
      logic [31:0] r;
      logic [35:0] exp;
      waited = 0;
      idx = 0;
      done = 1'b0;
      while (!done) begin
         r = lcg_next();
         // stall about three cycles in four
         rx_dst_rdy_n = (c_bp != 0) && (r[31:30] != 2'b00);
         if (!rx_src_rdy_n && !rx_dst_rdy_n) begin
            assert (idx < exp_words.size()) else abort_run("RX frame longer than expected");
            exp = exp_words[idx];
            check_value($sformatf("word %0d data", idx), exp[31:0], rx_d);
            check_value($sformatf("word %0d sof/sop/eop/eof", idx), {28'h0, exp[35:32]},
                        {28'h0, rx_sof_n, rx_sop_n, rx_eop_n, rx_eof_n});
            check_value($sformatf("word %0d rem", idx), 32'h0, {28'h0, rx_rem});
            done = !rx_eof_n;
            idx++;
         end
         waited++;
         assert (waited < WAIT_LIMIT) else abort_run("timeout waiting for the RX frame");
         @(negedge clk);
      end
      rx_dst_rdy_n = 1'b0;
      check_value("word count", exp_words.size(), idx);
   endtask

   task automatic wait_dcr_ack(input string what);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!dcr_ack) begin
         waited++;
         assert (waited < 20) else abort_run({"no DCR ack after ", what});
         @(negedge clk);
      end
   endtask

   task automatic dcr_read_check(input logic [3:0] addr, input logic [31:0] exp,
                                 input string what);
      dcr_abus = {6'h0, addr};
      dcr_read = 1'b1;
      wait_dcr_ack({"read of ", what});
      dcr_read = 1'b0;
      check_value(what, exp, dcr_dbus_out);
      @(negedge clk);
      check_value("ack release", 32'h0, dcr_ack);
   endtask

   task automatic engine_reset();
      int waited;
      // stalled partial frame, so the RX link is busy when the reset hits
      rx_dst_rdy_n = 1'b1;
      for (int i = 0; i < `COMP_HDR_WORDS; i++) begin
         send_word(lcg_next(), i != 0, 1'b1, 1'b1, 1'b1, 4'h0);
      end
      send_word(lcg_next(), 1'b1, 1'b0, 1'b1, 1'b1, 4'h0);
      send_word(lcg_next(), 1'b1, 1'b1, 1'b1, 1'b1, 4'h0);
      tx_src_rdy_n = 1'b1;
      waited = 0;
      while (rx_src_rdy_n) begin
         waited++;
         assert (waited < 20) else abort_run("RX link never offered the buffered beat");
         @(negedge clk);
      end
      dcr_abus = {6'h0, `COMP_REG_TX};
      // bit 31 in the big-endian numbering of the DCR word
      dcr_dbus_in = 32'h0000_0001;
      dcr_write = 1'b1;
      wait_dcr_ack("engine reset write");
      dcr_write = 1'b0;
      dcr_dbus_in = 32'h0;
      check_value("reset request", 32'h1, rst_engine_req);
      rst_engine_ack = 1'b1;
      @(negedge clk);
      check_value("reset request pulse", 32'h0, rst_engine_req);
      // DMA acknowledge held for three cycles
      repeat (3) begin
         check_rx_idle("rx outputs during engine reset");
         @(negedge clk);
      end
      rst_engine_ack = 1'b0;
      rx_dst_rdy_n = 1'b0;
      beats_total = 0;
      dcr_read_check(`COMP_REG_CNT, 32'h0, "beat count after engine reset");
   endtask

   initial begin
      int    fd;
      int    n;
      int    n_cases;
      string line;
      lcg_state = 32'h7398_18ba;
      rst_n = 1'b0;
      rst_engine_ack = 1'b0;
      tx_d = 32'h0;
      tx_rem = 4'h0;
      tx_sof_n = 1'b1;
      tx_eof_n = 1'b1;
      tx_sop_n = 1'b1;
      tx_eop_n = 1'b1;
      tx_src_rdy_n = 1'b1;
      rx_dst_rdy_n = 1'b0;
      dcr_abus = '0;
      dcr_dbus_in = '0;
      dcr_read = 1'b0;
      dcr_write = 1'b0;
      beats_total = 0;
      n_cases = 0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      case_name = "after_reset";
      check_value("tx ready", 32'h0, tx_dst_rdy_n);
      check_rx_idle("rx outputs");
      check_value("dcr ack", 32'h0, dcr_ack);
      check_value("engine request", 32'h0, rst_engine_req);
      case_name = "ident";
      dcr_read_check(`COMP_REG_ID, `COMP_ID_WORD, "id register");
      dcr_read_check(`COMP_REG_PAT, `COMP_PATTERN_WORD, "pattern register");

      fd = $fopen("testbench/comp_cases.txt", "r");
      assert (fd != 0) else abort_run("cannot open testbench/comp_cases.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%s %h %h %h %d %h %d %d %d", case_name, c_flags, c_src_len,
                     c_task, c_words, c_rem, c_bp, c_rst, c_len);
         assert (n == 9) else abort_run({"malformed case line: ", line});
         if (c_rst != 0) engine_reset();
         build_frame();
         fork
            send_frame();
            collect_frame();
         join
         beats_total += (c_words + 1) / 2;
         dcr_read_check(`COMP_REG_LEN, c_src_len, "length register");
         dcr_read_check(`COMP_REG_TASK, {c_flags, 19'h0, c_task}, "task register");
         dcr_read_check(`COMP_REG_CNT, {beats_total[15:0], 16'h0}, "beat count register");
         n_cases++;
      end
      $fclose(fd);
      assert (n_cases > 0) else abort_run("no test cases were read");
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== design/comp_unit.sv ====
`timescale 1ns/1ps

module comp_unit (
   input  logic         clk,
   input  logic         rst_n,
   output logic         rst_engine_req_o,
   input  logic         rst_engine_ack_i,
   // tx local link, DMA to unit
   input  logic [31:0]  tx_d_i,
   input  logic [3:0]   tx_rem_i,
   input  logic         tx_sof_n_i,
   input  logic         tx_eof_n_i,
   input  logic         tx_sop_n_i,
   input  logic         tx_eop_n_i,
   input  logic         tx_src_rdy_n_i,
   output logic         tx_dst_rdy_n_o,
   // rx local link, unit to DMA
   output logic [31:0]  rx_d_o,
   output logic [3:0]   rx_rem_o,
   output logic         rx_sof_n_o,
   output logic         rx_eof_n_o,
   output logic         rx_sop_n_o,
   output logic         rx_eop_n_o,
   output logic         rx_src_rdy_n_o,
   input  logic         rx_dst_rdy_n_i,
   // dcr port
   input  logic [0:9]   dcr_abus_i,
   input  logic [0:31]  dcr_dbus_i,
   input  logic         dcr_read_i,
   input  logic         dcr_write_i,
   output logic         dcr_ack_o,
   output logic [0:31]  dcr_dbus_o
);
   import comp_pkg::*;

   logic        eng_rst_n;
   logic        push;
   logic [63:0] push_data;
   logic        push_last;
   logic        beat_valid;
   logic [63:0] beat_data;
   logic        beat_last;
   logic        beat_pop;
   logic        buf_full;
   logic [15:0] beat_cnt;
   logic        frame_done;
   logic [2:0]  op_flags;
   logic [31:0] src_len;
   logic [9:0]  task_index;
   tx_state_e   tx_state;
   rx_state_e   rx_state;

   // engine held in reset by the request and by the DMA acknowledge
   assign eng_rst_n = rst_n && !rst_engine_req_o && !rst_engine_ack_i;

   tx_frame_parser u_tx (
      .clk            (clk),
      .rst_n          (eng_rst_n),
      .tx_d_i         (tx_d_i),
      .tx_rem_i       (tx_rem_i),
      .tx_sof_n_i     (tx_sof_n_i),
      .tx_eof_n_i     (tx_eof_n_i),
      .tx_sop_n_i     (tx_sop_n_i),
      .tx_eop_n_i     (tx_eop_n_i),
      .tx_src_rdy_n_i (tx_src_rdy_n_i),
      .buf_full_i     (buf_full),
      .frame_done_i   (frame_done),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .beat_push_o    (push),
      .beat_data_o    (push_data),
      .beat_last_o    (push_last),
      .op_flags_o     (op_flags),
      .src_len_o      (src_len),
      .task_index_o   (task_index),
      .tx_state_o     (tx_state)
   );

   // sits where the compression engine was
   beat_buffer u_buf (
      .clk        (clk),
      .rst_n      (eng_rst_n),
      .push_i     (push),
      .data_i     (push_data),
      .last_i     (push_last),
      .pop_i      (beat_pop),
      .valid_o    (beat_valid),
      .data_o     (beat_data),
      .last_o     (beat_last),
      .full_o     (buf_full),
      .beat_cnt_o (beat_cnt)
   );

   rx_frame_builder u_rx (
      .clk            (clk),
      .rst_n          (eng_rst_n),
      .beat_valid_i   (beat_valid),
      .beat_data_i    (beat_data),
      .beat_last_i    (beat_last),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .op_flags_i     (op_flags),
      .task_index_i   (task_index),
      .beat_cnt_i     (beat_cnt),
      .beat_pop_o     (beat_pop),
      .frame_done_o   (frame_done),
      .rx_d_o         (rx_d_o),
      .rx_rem_o       (rx_rem_o),
      .rx_sof_n_o     (rx_sof_n_o),
      .rx_eof_n_o     (rx_eof_n_o),
      .rx_sop_n_o     (rx_sop_n_o),
      .rx_eop_n_o     (rx_eop_n_o),
      .rx_src_rdy_n_o (rx_src_rdy_n_o),
      .rx_state_o     (rx_state)
   );

   dcr_status_regs u_dcr (
      .clk              (clk),
      .rst_n            (rst_n),
      .dcr_abus_i       (dcr_abus_i),
      .dcr_dbus_i       (dcr_dbus_i),
      .dcr_read_i       (dcr_read_i),
      .dcr_write_i      (dcr_write_i),
      .tx_state_i       (tx_state),
      .rx_state_i       (rx_state),
      .op_flags_i       (op_flags),
      .task_index_i     (task_index),
      .src_len_i        (src_len),
      .beat_cnt_i       (beat_cnt),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_dbus_o       (dcr_dbus_o),
      .rst_engine_req_o (rst_engine_req_o)
   );

endmodule

// ==== design/dcr_status_regs.sv ====
`timescale 1ns/1ps
`include "comp_macros.svh"

module dcr_status_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [0:9]          dcr_abus_i,
   input  logic [0:31]         dcr_dbus_i,
   input  logic                dcr_read_i,
   input  logic                dcr_write_i,
   input  comp_pkg::tx_state_e tx_state_i,
   input  comp_pkg::rx_state_e rx_state_i,
   input  logic [2:0]          op_flags_i,
   input  logic [9:0]          task_index_i,
   input  logic [31:0]         src_len_i,
   input  logic [15:0]         beat_cnt_i,
   output logic                dcr_ack_o,
   output logic [0:31]         dcr_dbus_o,
   output logic                rst_engine_req_o
);
   logic [0:31] reg_img;
   logic        rst_write;

   // big-endian image, bit 0 is the msb
   always_comb begin
      reg_img = '0;
      case (dcr_abus_i[6:9])
         `COMP_REG_TX: reg_img[0:3] = tx_state_i;
         `COMP_REG_RX: reg_img[0:3] = rx_state_i;
         `COMP_REG_TASK: begin
            reg_img[0:2] = op_flags_i;
            reg_img[22:31] = task_index_i;
         end
         `COMP_REG_CNT: reg_img[0:15] = beat_cnt_i;
         `COMP_REG_LEN: reg_img = src_len_i;
         `COMP_REG_ID: reg_img = `COMP_ID_WORD;
         `COMP_REG_PAT: reg_img = `COMP_PATTERN_WORD;
         default: ;
      endcase
   end

   assign rst_write = dcr_write_i && (dcr_abus_i == {6'h0, `COMP_REG_TX}) && dcr_dbus_i[31];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o <= 1'b0;
         rst_engine_req_o <= 1'b0;
      end else begin
         dcr_ack_o <= dcr_read_i || dcr_write_i;
         // one-shot even if the strobe lingers
         rst_engine_req_o <= rst_write && !rst_engine_req_o;
      end
   end

   always_ff @(posedge clk) begin
      dcr_dbus_o <= reg_img;
   end

endmodule

// ==== design/rx_frame_builder.sv ====
`timescale 1ns/1ps

module rx_frame_builder (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                beat_valid_i,
   input  logic [63:0]         beat_data_i,
   input  logic                beat_last_i,
   input  logic                rx_dst_rdy_n_i,
   input  logic [2:0]          op_flags_i,
   input  logic [9:0]          task_index_i,
   input  logic [15:0]         beat_cnt_i,
   output logic                beat_pop_o,
   output logic                frame_done_o,
   output logic [31:0]         rx_d_o,
   output logic [3:0]          rx_rem_o,
   output logic                rx_sof_n_o,
   output logic                rx_eof_n_o,
   output logic                rx_sop_n_o,
   output logic                rx_eop_n_o,
   output logic                rx_src_rdy_n_o,
   output comp_pkg::rx_state_e rx_state_o
);
   import comp_pkg::*;

   rx_state_e   rx_state;
   logic        first_word;
   logic [15:0] cnt_base;
   logic [15:0] frame_beats;
   logic        xfer;
   hdr_word_u   status_w;

   assign rx_state_o = rx_state;
   assign xfer = !rx_src_rdy_n_o && !rx_dst_rdy_n_i;
   // beat counter runs since reset, so subtract where the last frame ended
   assign frame_beats = beat_cnt_i - cnt_base;
   assign beat_pop_o = xfer && (rx_state == RX_PAY_ODD);
   assign frame_done_o = (rx_state == RX_DONE);
   assign rx_rem_o = 4'h0;

   always_comb begin
      status_w = '0;
      status_w.f.comp = op_flags_i[2];
      status_w.f.decomp = op_flags_i[1];
      status_w.f.copy = op_flags_i[0];
      status_w.f.status = 1'b1;
   end

   always_comb begin
      rx_d_o = 32'h0;
      rx_src_rdy_n_o = 1'b1;
      rx_sof_n_o = 1'b1;
      rx_sop_n_o = 1'b1;
      rx_eop_n_o = 1'b1;
      rx_eof_n_o = 1'b1;
      case (rx_state)
         RX_PAY_EVEN: begin
            rx_d_o = beat_data_i[63:32];
            rx_src_rdy_n_o = !beat_valid_i;
            rx_sof_n_o = !first_word;
            rx_sop_n_o = !first_word;
         end
         RX_PAY_ODD: begin
            rx_d_o = beat_data_i[31:0];
            rx_src_rdy_n_o = !beat_valid_i;
            rx_eop_n_o = !beat_last_i;
         end
         RX_STATUS: begin
            rx_d_o = status_w.raw;
            rx_src_rdy_n_o = 1'b0;
         end
         RX_LENGTH: begin
            // bytes, eight per beat
            rx_d_o = {13'h0, frame_beats, 3'h0};
            rx_src_rdy_n_o = 1'b0;
         end
         RX_TASK: begin
            rx_d_o = {22'h0, task_index_i};
            rx_src_rdy_n_o = 1'b0;
         end
         RX_EOF: begin
            rx_src_rdy_n_o = 1'b0;
            rx_eof_n_o = 1'b0;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_state <= RX_IDLE;
         first_word <= 1'b0;
         cnt_base <= '0;
      end else begin
         case (rx_state)
            RX_IDLE: begin
               if (beat_valid_i) begin
                  first_word <= 1'b1;
                  rx_state <= RX_PAY_EVEN;
               end
            end
            RX_PAY_EVEN: begin
               if (xfer) begin
                  first_word <= 1'b0;
                  rx_state <= RX_PAY_ODD;
               end
            end
            RX_PAY_ODD: begin
               if (xfer) begin
                  rx_state <= beat_last_i ? RX_STATUS : RX_PAY_EVEN;
               end
            end
            RX_STATUS: begin
               if (xfer) begin
                  rx_state <= RX_LENGTH;
               end
            end
            RX_LENGTH: begin
               if (xfer) begin
                  rx_state <= RX_TASK;
               end
            end
            RX_TASK: begin
               if (xfer) begin
                  rx_state <= RX_EOF;
               end
            end
            RX_EOF: begin
               if (xfer) begin
                  rx_state <= RX_DONE;
               end
            end
            RX_DONE: begin
               cnt_base <= beat_cnt_i;
               rx_state <= RX_IDLE;
            end
            default: rx_state <= RX_IDLE;
         endcase
      end
   end

   // offered word and flags hold while the DMA stalls
   assert property (@(posedge clk) disable iff (!rst_n)
      (!rx_src_rdy_n_o && rx_dst_rdy_n_i) |=>
         (!rx_src_rdy_n_o && $stable(rx_d_o) &&
          $stable({rx_sof_n_o, rx_sop_n_o, rx_eop_n_o, rx_eof_n_o})));

endmodule

// ==== design/beat_buffer.sv ====
`timescale 1ns/1ps
`include "comp_macros.svh"

module beat_buffer (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        push_i,
   input  logic [63:0] data_i,
   input  logic        last_i,
   input  logic        pop_i,
   output logic        valid_o,
   output logic [63:0] data_o,
   output logic        last_o,
   output logic        full_o,
   output logic [15:0] beat_cnt_o
);
   // depth is a power of two, pointers wrap on their own
   localparam int DEPTH = `COMP_FIFO_DEPTH;
   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

   logic [64:0]   mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;

   assign valid_o = (count != '0);
   assign full_o = (count == FULL_CNT);
   assign {last_o, data_o} = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr] <= {last_i, data_i};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         beat_cnt_o <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
            beat_cnt_o <= beat_cnt_o + 16'd1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // parser stalls on full, builder pops only a valid beat
   assert property (@(posedge clk) disable iff (!rst_n) !(push_i && full_o));
   assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && !valid_o));

endmodule

// ==== design/tx_frame_parser.sv ====
`timescale 1ns/1ps
`include "comp_macros.svh"

module tx_frame_parser (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [31:0]         tx_d_i,
   input  logic [3:0]          tx_rem_i,
   input  logic                tx_sof_n_i,
   input  logic                tx_eof_n_i,
   input  logic                tx_sop_n_i,
   input  logic                tx_eop_n_i,
   input  logic                tx_src_rdy_n_i,
   input  logic                buf_full_i,
   input  logic                frame_done_i,
   output logic                tx_dst_rdy_n_o,
   output logic                beat_push_o,
   output logic [63:0]         beat_data_o,
   output logic                beat_last_o,
   output logic [2:0]          op_flags_o,
   output logic [31:0]         src_len_o,
   output logic [9:0]          task_index_o,
   output comp_pkg::tx_state_e tx_state_o
);
   import comp_pkg::*;

   tx_state_e   tx_state;
   logic [2:0]  hdr_cnt;
   logic [31:0] hi_word;
   logic [31:0] pay_word;
   logic        first_pay;
   logic        fin_seen;
   logic        xfer;
   hdr_word_u   flag_w;

   // zero the byte lanes the remainder marks invalid
   function automatic logic [31:0] mask_word(input logic [31:0] d, input logic [3:0] rem);
      logic [31:0] m;
      case (rem)
         4'b0001: m = {d[31:8], 8'h0};
         4'b0011: m = {d[31:16], 16'h0};
         4'b0111: m = {d[31:24], 24'h0};
         default: m = d;
      endcase
      return m;
   endfunction

   assign tx_dst_rdy_n_o = buf_full_i || (tx_state == TX_DONE);
   assign xfer = !tx_src_rdy_n_i && !tx_dst_rdy_n_o;
   assign tx_state_o = tx_state;
   assign flag_w.raw = tx_d_i;
   assign pay_word = tx_eop_n_i ? tx_d_i : mask_word(tx_d_i, tx_rem_i);

   // beat completes on the odd word, or early when EOP lands on an even one
   assign beat_push_o = xfer && ((tx_state == TX_PAY_ODD) ||
                                 (tx_state == TX_PAY_EVEN && !tx_eop_n_i));
   assign beat_data_o = (tx_state == TX_PAY_ODD) ? {hi_word, pay_word} : {pay_word, 32'h0};
   assign beat_last_o = !tx_eop_n_i;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= TX_IDLE;
         hdr_cnt <= '0;
         first_pay <= 1'b0;
         fin_seen <= 1'b0;
         op_flags_o <= '0;
         src_len_o <= '0;
         task_index_o <= '0;
      end else begin
         // rx side may finish before the trailer word is taken
         if (frame_done_i) begin
            fin_seen <= 1'b1;
         end
         case (tx_state)
            TX_IDLE: begin
               if (xfer && !tx_sof_n_i) begin
                  hdr_cnt <= 3'd1;
                  tx_state <= TX_HEADER;
               end
            end
            TX_HEADER: begin
               if (xfer) begin
                  case (hdr_cnt)
                     3'(`COMP_FLAG_WORD): begin
                        op_flags_o <= {flag_w.f.comp, flag_w.f.decomp, flag_w.f.copy};
                     end
                     3'(`COMP_LEN_WORD): src_len_o <= tx_d_i;
                     3'(`COMP_TASK_WORD): task_index_o <= tx_d_i[9:0];
                     default: ;
                  endcase
                  hdr_cnt <= hdr_cnt + 3'd1;
                  if (hdr_cnt == 3'(`COMP_HDR_WORDS - 1)) begin
                     first_pay <= 1'b1;
                     tx_state <= TX_PAY_EVEN;
                  end
               end
            end
            TX_PAY_EVEN: begin
               if (xfer) begin
                  first_pay <= 1'b0;
                  tx_state <= tx_eop_n_i ? TX_PAY_ODD : TX_TRAILER;
               end
            end
            TX_PAY_ODD: begin
               if (xfer) begin
                  tx_state <= tx_eop_n_i ? TX_PAY_EVEN : TX_TRAILER;
               end
            end
            TX_TRAILER: begin
               if (xfer && !tx_eof_n_i) begin
                  tx_state <= TX_DONE;
               end
            end
            TX_DONE: begin
               if (fin_seen || frame_done_i) begin
                  fin_seen <= 1'b0;
                  tx_state <= TX_IDLE;
               end
            end
            default: tx_state <= TX_IDLE;
         endcase
      end
   end

   // high half of the beat being paired
   always_ff @(posedge clk) begin
      if (xfer && tx_state == TX_PAY_EVEN) begin
         hi_word <= pay_word;
      end
   end

   // sop only on the first word after the header
   assert property (@(posedge clk) disable iff (!rst_n)
      xfer |-> (!tx_sop_n_i == first_pay));

endmodule

// ==== design/comp_pkg.sv ====
package comp_pkg;

   // descriptor flag word, also the completion status word
   typedef struct packed {
      logic        comp;
      logic        decomp;
      logic        copy;
      logic        status;
      logic [27:0] rsvd;
   } hdr_fields_t;

   typedef union packed {
      logic [31:0] raw;
      hdr_fields_t f;
   } hdr_word_u;

   typedef enum logic [3:0] {
      TX_IDLE,
      TX_HEADER,
      TX_PAY_EVEN,
      TX_PAY_ODD,
      TX_TRAILER,
      TX_DONE
   } tx_state_e;

   typedef enum logic [3:0] {
      RX_IDLE,
      RX_PAY_EVEN,
      RX_PAY_ODD,
      RX_STATUS,
      RX_LENGTH,
      RX_TASK,
      RX_EOF,
      RX_DONE
   } rx_state_e;

endpackage

// ==== include/comp_macros.svh ====
`ifndef COMP_MACROS_SVH
`define COMP_MACROS_SVH

// descriptor header layout
`define COMP_HDR_WORDS 8
`define COMP_FLAG_WORD 4
`define COMP_LEN_WORD 5
`define COMP_TASK_WORD 6

// payload buffer depth in 64-bit beats
`define COMP_FIFO_DEPTH 16

// identification read values
`define COMP_ID_WORD 32'h1006_2500
`define COMP_PATTERN_WORD 32'haa55_55aa

// register addresses, low four bits of the DCR address
`define COMP_REG_TX 4'h0
`define COMP_REG_RX 4'h1
`define COMP_REG_TASK 4'h2
`define COMP_REG_CNT 4'h4
`define COMP_REG_LEN 4'h5
`define COMP_REG_ID 4'he
`define COMP_REG_PAT 4'hf

`endif
